/* src/ipod_pkg.sv */
package ipod_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================

  // Flash word address and data
  localparam int addr_w   = 23;
  localparam int data_w   = 32;

  // Signed audio sample
  localparam int sample_w = 8;

  // Half-period divisor in CLK_50M cycles
  localparam int div_w    = 32;

  // ==========================================================================
  // Keyboard command codes
  // ==========================================================================

  typedef logic [7:0] ascii_t;

  localparam ascii_t key_play     = 8'h45;  // E
  localparam ascii_t key_stop     = 8'h44;  // D
  localparam ascii_t key_forward  = 8'h46;  // F
  localparam ascii_t key_backward = 8'h42;  // B
  localparam ascii_t key_restart  = 8'h52;  // R

  // ==========================================================================
  // Bus structs
  // ==========================================================================

  // Read request towards the flash
  typedef struct packed {
    logic              read;
    logic [addr_w-1:0] address;
  } flash_req_t;

  // Flash response
  typedef struct packed {
    logic              waitrequest;
    logic              readdatavalid;
    logic [data_w-1:0] readdata;
  } flash_rsp_t;

  // Playback controls, restart is a single-cycle pulse
  typedef struct packed {
    logic play;
    logic forward;
    logic restart;
  } play_ctrl_t;

endpackage

/* src/kbd_command.sv */
`timescale 1ns/1ns

module kbd_command (
  input  logic                CLK_50M,
  input  logic                arst_n,
  input  logic                key_valid,
  input  ipod_pkg::ascii_t    key_ascii,
  output ipod_pkg::play_ctrl_t ctrl
);

  import ipod_pkg::*;

  // Decoded command strobes for the current key
  logic cmd_play;
  logic cmd_stop;
  logic cmd_forward;
  logic cmd_backward;
  logic cmd_restart;

  assign cmd_play     = key_valid && (key_ascii == key_play);
  assign cmd_stop     = key_valid && (key_ascii == key_stop);
  assign cmd_forward  = key_valid && (key_ascii == key_forward);
  assign cmd_backward = key_valid && (key_ascii == key_backward);
  assign cmd_restart  = key_valid && (key_ascii == key_restart);

  // ==========================================================================
  // Control register
  // ==========================================================================

  // Play and direction hold their level, other characters change nothing
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctrl.play    <= 1'b0;
      ctrl.forward <= 1'b1;
      ctrl.restart <= 1'b0;
    end
    else
    begin
      if (cmd_play)
      begin
        ctrl.play <= 1'b1;
      end
      else if (cmd_stop)
      begin
        ctrl.play <= 1'b0;
      end

      if (cmd_forward)
      begin
        ctrl.forward <= 1'b1;
      end
      else if (cmd_backward)
      begin
        ctrl.forward <= 1'b0;
      end

      // High for the one cycle after the R strobe
      ctrl.restart <= cmd_restart;
    end
  end

endmodule

/* src/speed_ctrl.sv */
`timescale 1ns/1ns

module speed_ctrl #(
  parameter int unsigned                  repeat_cycles = 5_000_000,
  parameter logic [ipod_pkg::div_w-1:0]   speed_step    = 32'd16,
  parameter logic [ipod_pkg::div_w-1:0]   div_default   = 32'd1136,
  parameter logic [ipod_pkg::div_w-1:0]   div_min       = 32'd284,
  parameter logic [ipod_pkg::div_w-1:0]   div_max       = 32'd4544
) (
  input  logic                        CLK_50M,
  input  logic                        arst_n,
  input  logic                        speed_up,
  input  logic                        speed_down,
  input  logic                        speed_reset,
  output logic [ipod_pkg::div_w-1:0]  rate_divisor
);

  import ipod_pkg::*;

  localparam int cnt_w = (repeat_cycles > 1) ? $clog2(repeat_cycles) : 1;

  // Button order in the sync vectors is {reset, down, up}
  logic [2:0]         btn_meta;
  logic [2:0]         btn_sync;
  logic [cnt_w-1:0]   rpt_cnt;
  logic               rpt_last;
  logic [div_w-1:0]   div_next;

  // ==========================================================================
  // Button synchronisers
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      btn_meta <= '0;
      btn_sync <= '0;
    end
    else
    begin
      btn_meta <= {speed_reset, speed_down, speed_up};
      btn_sync <= btn_meta;
    end
  end

  // ==========================================================================
  // Repeat counter
  // ==========================================================================

  assign rpt_last = (rpt_cnt == cnt_w'(repeat_cycles - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rpt_cnt <= '0;
    else if (rpt_last)
      rpt_cnt <= '0;
    else
      rpt_cnt <= rpt_cnt + 1'b1;
  end

  // ==========================================================================
  // Divisor register
  // ==========================================================================

  // Reset button first, then one clamped step per repeat period
  always_comb
  begin
    div_next = rate_divisor;
    if (btn_sync[2])
    begin
      div_next = div_default;
    end
    else if (rpt_last)
    begin
      if (btn_sync[0] && !btn_sync[1])
        div_next = (rate_divisor < div_min + speed_step) ? div_min
                                                         : rate_divisor - speed_step;
      else if (btn_sync[1] && !btn_sync[0])
        div_next = (rate_divisor > div_max - speed_step) ? div_max
                                                         : rate_divisor + speed_step;
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rate_divisor <= div_default;
    else
      rate_divisor <= div_next;
  end

endmodule

/* src/sample_tick_gen.sv */
`timescale 1ns/1ns

module sample_tick_gen (
  input  logic                        CLK_50M,
  input  logic                        arst_n,
  input  logic                        play,
  input  logic [ipod_pkg::div_w-1:0]  rate_divisor,
  output logic                        tick
);

  import ipod_pkg::*;

  logic [div_w-1:0] count;
  logic             phase;
  logic             half_done;

  // End of one half period; >= keeps it safe when the divisor shrinks
  assign half_done = (count >= rate_divisor - 1'b1);

  // Count and phase sit at zero while stopped
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= '0;
      phase <= 1'b0;
      tick  <= 1'b0;
    end
    else if (!play)
    begin
      count <= '0;
      phase <= 1'b0;
      tick  <= 1'b0;
    end
    else
    begin
      tick <= 1'b0;
      if (half_done)
      begin
        count <= '0;
        phase <= ~phase;
        // One tick per full period, on the rising phase
        tick  <= ~phase;
      end
      else
      begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

/* src/flash_reader.sv */
`timescale 1ns/1ns

module flash_reader (
  input  logic                                 CLK_50M,
  input  logic                                 arst_n,
  input  logic                                 tick,
  input  logic [ipod_pkg::addr_w-1:0]          address,
  input  ipod_pkg::flash_rsp_t                 flash_rsp,
  output logic                                 read,
  output logic signed [ipod_pkg::sample_w-1:0] sample,
  output logic                                 sample_valid
);

  import ipod_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data
  } rd_state_t;

  rd_state_t           state;
  logic [sample_w-1:0] byte_sel;

  // Odd word address plays the upper byte, even the second byte
  assign byte_sel = address[0] ? flash_rsp.readdata[31:24]
                               : flash_rsp.readdata[15:8];

  // Read stays up with a stable address until waitrequest drops
  assign read = (state == st_request);

  // ==========================================================================
  // Read FSM
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= st_idle;
      sample       <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        st_idle:
        begin
          if (tick)
            state <= st_request;
        end

        st_request:
        begin
          if (!flash_rsp.waitrequest)
            state <= st_wait_data;
        end

        st_wait_data:
        begin
          // Ticks during the whole read are dropped
          if (flash_rsp.readdatavalid)
          begin
            sample       <= $signed(byte_sel);
            sample_valid <= 1'b1;
            state        <= st_idle;
          end
        end

        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

/* src/addr_counter.sv */
`timescale 1ns/1ns

module addr_counter #(
  parameter logic [ipod_pkg::addr_w-1:0] addr_last = 23'h7FFFF
) (
  input  logic                        CLK_50M,
  input  logic                        arst_n,
  input  ipod_pkg::play_ctrl_t        ctrl,
  input  logic                        step,
  output logic [ipod_pkg::addr_w-1:0] address
);

  import ipod_pkg::*;

  logic [addr_w-1:0] addr_fwd;
  logic [addr_w-1:0] addr_bwd;
  logic [addr_w-1:0] addr_start;

  // Next address in each direction, wrapping at both ends
  assign addr_fwd = (address == addr_last) ? '0 : address + 1'b1;
  assign addr_bwd = (address == '0) ? addr_last : address - 1'b1;

  // Backward playback starts from the end of the clip
  assign addr_start = ctrl.forward ? '0 : addr_last;

  // ==========================================================================
  // Address register
  // ==========================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      address <= '0;
    end
    else if (ctrl.restart)
    begin
      address <= addr_start;
    end
    else if (step)
    begin
      if (ctrl.forward)
        address <= addr_fwd;
      else
        address <= addr_bwd;
    end
  end

endmodule

/* src/ipod_top.sv */
`timescale 1ns/1ns

module ipod_top #(
  parameter logic [ipod_pkg::addr_w-1:0] addr_last     = 23'h7FFFF,
  parameter int unsigned                 repeat_cycles = 5_000_000,
  parameter logic [ipod_pkg::div_w-1:0]  speed_step    = 32'd16,
  parameter logic [ipod_pkg::div_w-1:0]  div_default   = 32'd1136,
  parameter logic [ipod_pkg::div_w-1:0]  div_min       = 32'd284,
  parameter logic [ipod_pkg::div_w-1:0]  div_max       = 32'd4544
) (
  input  logic                                 CLK_50M,
  input  logic                                 arst_n,
  input  logic                                 key_valid,
  input  ipod_pkg::ascii_t                     key_ascii,
  input  logic                                 speed_up,
  input  logic                                 speed_down,
  input  logic                                 speed_reset,
  input  ipod_pkg::flash_rsp_t                 flash_rsp,
  output ipod_pkg::flash_req_t                 flash_req,
  output logic signed [ipod_pkg::sample_w-1:0] sample,
  output logic                                 sample_valid,
  output logic [ipod_pkg::div_w-1:0]           rate_divisor
);

  import ipod_pkg::*;

  play_ctrl_t        ctrl;
  logic              tick;
  logic              read;
  logic [addr_w-1:0] address;

  assign flash_req = '{read: read, address: address};

  // ==========================================================================
  // Control path
  // ==========================================================================

  kbd_command kbd_command_i (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .key_valid (key_valid),
    .key_ascii (key_ascii),
    .ctrl      (ctrl)
  );

  speed_ctrl #(
    .repeat_cycles (repeat_cycles),
    .speed_step    (speed_step),
    .div_default   (div_default),
    .div_min       (div_min),
    .div_max       (div_max)
  ) speed_ctrl_i (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .speed_up     (speed_up),
    .speed_down   (speed_down),
    .speed_reset  (speed_reset),
    .rate_divisor (rate_divisor)
  );

  sample_tick_gen sample_tick_gen_i (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .play         (ctrl.play),
    .rate_divisor (rate_divisor),
    .tick         (tick)
  );

  // ==========================================================================
  // Flash path
  // ==========================================================================

  flash_reader flash_reader_i (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .tick         (tick),
    .address      (address),
    .flash_rsp    (flash_rsp),
    .read         (read),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  // Each finished sample advances the address
  addr_counter #(
    .addr_last (addr_last)
  ) addr_counter_i (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .ctrl    (ctrl),
    .step    (sample_valid),
    .address (address)
  );

endmodule

/* sim/flash_model.sv */
`timescale 1ns/1ns

module flash_model (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::flash_req_t req,
  output ipod_pkg::flash_rsp_t rsp,
  output int                   proto_errors
);

  import ipod_pkg::*;

  logic [31:0]       lfsr = 32'he556;
  logic              busy;
  logic [2:0]        lat_cnt;
  logic [addr_w-1:0] rd_addr;
  flash_req_t        prev_req;
  logic              prev_wait;
  logic              rnd_lo;
  logic              rnd_hi;
  logic              rnd_wait;

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rsp       <= '0;
      busy      <= 1'b0;
      lat_cnt   <= '0;
      rd_addr   <= '0;
      prev_req  <= '0;
      prev_wait <= 1'b0;
    end
    else
    begin
      // A stalled request has to stay put
      if (prev_req.read && prev_wait && (req != prev_req))
      begin
        $display("Flash protocol failure at %0t ns: read or address changed under waitrequest",
                 $time);
        proto_errors++;
      end
      prev_req          <= req;
      prev_wait         <= rsp.waitrequest;
      rsp.readdatavalid <= 1'b0;
      if (busy)
      begin
        if (lat_cnt == 3'd1)
        begin
          rsp.readdatavalid <= 1'b1;
          rsp.readdata      <= {rd_addr[7:0], 8'h5A, ~rd_addr[7:0], 8'h5A};
          busy              <= 1'b0;
        end
        else
          lat_cnt <= lat_cnt - 3'd1;
      end
      if (req.read && !rsp.waitrequest)
      begin
        if (busy)
        begin
          $display("Flash protocol failure at %0t ns: second read before the first one's data",
                   $time);
          proto_errors++;
        end
        take_bit(rnd_lo);
        take_bit(rnd_hi);
        busy    <= 1'b1;
        rd_addr <= req.address;
        // Latency of 1 to 4 cycles
        lat_cnt <= {1'b0, rnd_hi, rnd_lo} + 3'd1;
      end
      take_bit(rnd_wait);
      rsp.waitrequest <= rnd_wait;
    end
  end

endmodule

/* sim/tb_ipod.sv */
`timescale 1ns/1ns

module tb_ipod;

  import ipod_pkg::*;

  localparam logic [addr_w-1:0] addr_last     = 23'd5;
  localparam int unsigned       repeat_cycles = 16;
  localparam logic [div_w-1:0]  speed_step    = 32'd2;
  localparam logic [div_w-1:0]  div_default   = 32'd8;
  localparam logic [div_w-1:0]  div_min       = 32'd4;
  localparam logic [div_w-1:0]  div_max       = 32'd12;

  logic                       CLK_50M;
  logic                       arst_n;
  logic                       key_valid;
  ascii_t                     key_ascii;
  logic                       speed_up;
  logic                       speed_down;
  logic                       speed_reset;
  flash_req_t                 flash_req;
  flash_rsp_t                 flash_rsp;
  logic signed [sample_w-1:0] sample;
  logic                       sample_valid;
  logic [div_w-1:0]           rate_divisor;
  int                         proto_errors;

  // Reference model state
  logic [addr_w-1:0]   exp_addr;
  logic                exp_fwd;
  logic [sample_w-1:0] exp_sample;
  logic                outstanding;
  int                  samples;
  int                  errors;
  int                  cycles;
  int                  limit;
  int                  budget;
  int                  fd;
  int                  num;
  bit                  got;
  logic [7:0]          op;

  ipod_top #(
    .addr_last     (addr_last),
    .repeat_cycles (repeat_cycles),
    .speed_step    (speed_step),
    .div_default   (div_default),
    .div_min       (div_min),
    .div_max       (div_max)
  ) ipod_top_i (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .key_valid    (key_valid),
    .key_ascii    (key_ascii),
    .speed_up     (speed_up),
    .speed_down   (speed_down),
    .speed_reset  (speed_reset),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .sample       (sample),
    .sample_valid (sample_valid),
    .rate_divisor (rate_divisor)
  );

  flash_model flash_model_i (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .req          (flash_req),
    .rsp          (flash_rsp),
    .proto_errors (proto_errors)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  always @(posedge CLK_50M)
  begin
    cycles++;
    if (limit != 0 && cycles > limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic skip_line();
    int c;
    c = 0;
    while (c != "\n" && c != -1)
      c = $fgetc(fd);
  endtask

  // Reads the next command and skips # lines
  task automatic read_command(output bit ok, output logic [7:0] code, output int arg);
    int         rc;
    logic [7:0] ch;
    ok   = 1'b0;
    arg  = 0;
    rc   = $fscanf(fd, " %c", code);
    while (rc == 1 && code == "#")
    begin
      skip_line();
      rc = $fscanf(fd, " %c", code);
    end
    if (rc == 1)
    begin
      ok = 1'b1;
      if (code == "K")
      begin
        rc  = $fscanf(fd, " %c", ch);
        arg = ch;
      end
      else
        rc = $fscanf(fd, " %d", arg);
    end
  endtask

  task automatic press_key(input logic [7:0] ch);
    key_valid = 1'b1;
    key_ascii = ch;
    @(negedge CLK_50M);
    key_valid = 1'b0;
    case (ch)
      "F": exp_fwd = 1'b1;
      "B": exp_fwd = 1'b0;
      "R": exp_addr = exp_fwd ? '0 : addr_last;
      default: ;
    endcase
    // A read started just before the stop still completes
    if (ch == "D")
    begin
      repeat (3) @(negedge CLK_50M);
      while (flash_req.read || outstanding)
        @(negedge CLK_50M);
    end
  endtask

  task automatic hold_button(input logic [7:0] which, input int n);
    case (which)
      "U": speed_up = 1'b1;
      "N": speed_down = 1'b1;
      default: speed_reset = 1'b1;
    endcase
    repeat (n) @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    // Synchroniser delay
    repeat (4) @(negedge CLK_50M);
  endtask

  task automatic run_samples(input int n);
    int target;
    target = samples + n;
    while (samples < target)
      @(negedge CLK_50M);
  endtask

  task automatic idle_window(input int n);
    repeat (n)
    begin
      @(negedge CLK_50M);
      if (flash_req.read || sample_valid)
        report_error("read or sample_valid active while stopped");
    end
  endtask

  // ==========================================================================
  // Reference model and bus monitor
  // ==========================================================================

  always @(posedge CLK_50M)
  begin
    if (arst_n)
    begin
      if (flash_req.read && !flash_rsp.waitrequest)
      begin
        if (flash_req.address !== exp_addr)
          report_error($sformatf("read address %0d, expected %0d", flash_req.address, exp_addr));
        if (outstanding)
          report_error("read accepted while another read is outstanding");
        outstanding = 1'b1;
      end
      if (sample_valid)
      begin
        exp_sample = exp_addr[0] ? exp_addr[7:0] : ~exp_addr[7:0];
        if (sample !== exp_sample)
          report_error($sformatf("sample %h at address %0d, expected %h",
                                 sample, exp_addr, exp_sample));
        if (!outstanding)
          report_error("sample_valid without an accepted read");
        outstanding = 1'b0;
        samples++;
        if (exp_fwd)
          exp_addr = (exp_addr == addr_last) ? '0 : exp_addr + 1'b1;
        else
          exp_addr = (exp_addr == '0) ? addr_last : exp_addr - 1'b1;
      end
    end
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial
  begin
    arst_n      = 1'b0;
    key_valid   = 1'b0;
    key_ascii   = '0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_addr    = '0;
    exp_fwd     = 1'b1;
    outstanding = 1'b0;
    samples     = 0;
    errors      = 0;
    cycles      = 0;
    limit       = 0;

    // First pass sizes the timeout
    budget = 1000;
    fd = $fopen("sim/ipod_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the stimulus file sim/ipod_stim.txt");
      errors++;
    end
    read_command(got, op, num);
    while (got)
    begin
      if (op == "S")
        budget += 40 * 2 * int'(div_max) * num;
      else if (op == "U" || op == "N" || op == "Z" || op == "I")
        budget += num + 4;
      read_command(got, op, num);
    end
    $fclose(fd);
    limit = budget;

    repeat (10) @(negedge CLK_50M);
    arst_n = 1'b1;
    @(negedge CLK_50M);
    if (flash_req.read || sample_valid || rate_divisor !== div_default)
      report_error("outputs after reset differ from their reset values");

    fd = $fopen("sim/ipod_stim.txt", "r");
    read_command(got, op, num);
    while (got)
    begin
      case (op)
        "K": press_key(num[7:0]);
        "U", "N", "Z": hold_button(op, num);
        "S": run_samples(num);
        "I": idle_window(num);
        "V":
        begin
          if (rate_divisor !== num)
            report_error($sformatf("rate_divisor %0d, expected %0d", rate_divisor, num));
        end
        default:
        begin
          $display("Unknown command %c in the stimulus file", op);
          errors++;
        end
      endcase
      read_command(got, op, num);
    end
    $fclose(fd);

    repeat (4) @(negedge CLK_50M);
    $display("Errors: %0d checks, %0d flash protocol", errors, proto_errors);
    if (errors == 0 && proto_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* sim/ipod_stim.txt */
# K key char, U/N/Z hold up/down/reset button for n cycles
# S wait for n samples, I idle n cycles, V expected rate_divisor
V 8
K E
S 8
K D
I 48
K E
S 3
K D
K B
K R
K E
S 8
K D
K F
K R
K E
S 4
K D
U 16
V 6
U 16
U 16
V 4
N 16
N 16
N 16
N 16
N 16
V 12
Z 4
V 8

/* build.f */
src/ipod_pkg.sv
src/kbd_command.sv
src/speed_ctrl.sv
src/sample_tick_gen.sv
src/flash_reader.sv
src/addr_counter.sv
src/ipod_top.sv
sim/flash_model.sv
sim/tb_ipod.sv
